// File: verilog/karatsubaPkg.sv
package karatsubaPkg;

    // ==================================================
    // Operand and product widths
    // ==================================================
    localparam int OPERAND_WIDTH = 24;
    localparam int HALF_WIDTH = 12;
    // One extra bit so a half sum keeps its carry
    localparam int LEAF_WIDTH = 13;
    localparam int LEAF_PRODUCT_WIDTH = 26;
    localparam int PRODUCT_WIDTH = 48;
    localparam int TAG_WIDTH = 4;

    // Request to response, in clocks
    localparam int PIPE_LATENCY = 4;

    // ==================================================
    // Leaf organization
    // ==================================================
    localparam int NUM_LEAVES = 3;
    localparam int LEAF_HIGH = 0;
    localparam int LEAF_LOW = 1;
    localparam int LEAF_SUM = 2;

    // Chunking inside a leaf, 13 bits as 7 low plus 6 high
    localparam int LEAF_CHUNK_LOW_WIDTH = 7;
    localparam int LEAF_CHUNK_HIGH_WIDTH = LEAF_WIDTH - LEAF_CHUNK_LOW_WIDTH;
    localparam int LEAF_PP_LOW_WIDTH = 2 * LEAF_CHUNK_LOW_WIDTH;
    localparam int LEAF_PP_CROSS_WIDTH = LEAF_CHUNK_LOW_WIDTH + LEAF_CHUNK_HIGH_WIDTH;
    localparam int LEAF_PP_HIGH_WIDTH = 2 * LEAF_CHUNK_HIGH_WIDTH;
    // Two cross products added together need one more bit
    localparam int LEAF_CROSS_SUM_WIDTH = LEAF_PP_CROSS_WIDTH + 1;

    // ==================================================
    // Payload structs
    // ==================================================
    typedef struct packed {
        logic                     valid;
        logic [TAG_WIDTH-1:0]     tag;
        logic [OPERAND_WIDTH-1:0] operandA;
        logic [OPERAND_WIDTH-1:0] operandB;
    } mulRequest_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [LEAF_WIDTH-1:0] operandA;
        logic [LEAF_WIDTH-1:0] operandB;
    } leafJob_t;

    typedef struct packed {
        logic                          valid;
        logic [TAG_WIDTH-1:0]          tag;
        logic [LEAF_PRODUCT_WIDTH-1:0] product;
    } leafResult_t;

    typedef struct packed {
        logic                     valid;
        logic [TAG_WIDTH-1:0]     tag;
        logic [PRODUCT_WIDTH-1:0] product;
    } mulResponse_t;

endpackage

// File: verilog/karatsubaSplitter.sv
module karatsubaSplitter (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  karatsubaPkg::mulRequest_t                              req_i,
    output karatsubaPkg::leafJob_t [karatsubaPkg::NUM_LEAVES-1:0] jobs_o
);

    // Operand halves
    logic [karatsubaPkg::HALF_WIDTH-1:0] aHigh;
    logic [karatsubaPkg::HALF_WIDTH-1:0] aLow;
    logic [karatsubaPkg::HALF_WIDTH-1:0] bHigh;
    logic [karatsubaPkg::HALF_WIDTH-1:0] bLow;

    // Halves widened to leaf width
    logic [karatsubaPkg::LEAF_WIDTH-1:0] aHighExt;
    logic [karatsubaPkg::LEAF_WIDTH-1:0] aLowExt;
    logic [karatsubaPkg::LEAF_WIDTH-1:0] bHighExt;
    logic [karatsubaPkg::LEAF_WIDTH-1:0] bLowExt;

    // Karatsuba half sums, carry kept in the top bit
    logic [karatsubaPkg::LEAF_WIDTH-1:0] aSum;
    logic [karatsubaPkg::LEAF_WIDTH-1:0] bSum;

    karatsubaPkg::leafJob_t [karatsubaPkg::NUM_LEAVES-1:0] nextJobs;

    // ==================================================
    // Operand split
    // ==================================================
    assign aHigh = req_i.operandA[karatsubaPkg::OPERAND_WIDTH-1 -: karatsubaPkg::HALF_WIDTH];
    assign aLow  = req_i.operandA[karatsubaPkg::HALF_WIDTH-1:0];
    assign bHigh = req_i.operandB[karatsubaPkg::OPERAND_WIDTH-1 -: karatsubaPkg::HALF_WIDTH];
    assign bLow  = req_i.operandB[karatsubaPkg::HALF_WIDTH-1:0];

    assign aHighExt = {{(karatsubaPkg::LEAF_WIDTH - karatsubaPkg::HALF_WIDTH){1'b0}}, aHigh};
    assign aLowExt  = {{(karatsubaPkg::LEAF_WIDTH - karatsubaPkg::HALF_WIDTH){1'b0}}, aLow};
    assign bHighExt = {{(karatsubaPkg::LEAF_WIDTH - karatsubaPkg::HALF_WIDTH){1'b0}}, bHigh};
    assign bLowExt  = {{(karatsubaPkg::LEAF_WIDTH - karatsubaPkg::HALF_WIDTH){1'b0}}, bLow};

    assign aSum = aHighExt + aLowExt;
    assign bSum = bHighExt + bLowExt;

    // ==================================================
    // Job building
    // ==================================================
    always_comb begin
        // Same strobe and tag into every leaf
        for (int leafIdx = 0; leafIdx < karatsubaPkg::NUM_LEAVES; leafIdx++) begin
            nextJobs[leafIdx].valid = req_i.valid;
            nextJobs[leafIdx].tag   = req_i.tag;
        end
        nextJobs[karatsubaPkg::LEAF_HIGH].operandA = aHighExt;
        nextJobs[karatsubaPkg::LEAF_HIGH].operandB = bHighExt;
        nextJobs[karatsubaPkg::LEAF_LOW].operandA  = aLowExt;
        nextJobs[karatsubaPkg::LEAF_LOW].operandB  = bLowExt;
        nextJobs[karatsubaPkg::LEAF_SUM].operandA  = aSum;
        nextJobs[karatsubaPkg::LEAF_SUM].operandB  = bSum;
    end

    // Payload loads every cycle, valid bits cleared on reset
    always_ff @(posedge clk) begin
        jobs_o <= nextJobs;
        if (rst_i) begin
            for (int leafIdx = 0; leafIdx < karatsubaPkg::NUM_LEAVES; leafIdx++) begin
                jobs_o[leafIdx].valid <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/karatsubaLeaf.sv
module karatsubaLeaf (
    input  logic                      clk,
    input  logic                      rst_i,
    input  karatsubaPkg::leafJob_t    job_i,
    output karatsubaPkg::leafResult_t result_o
);

    // Stage one contents, four chunk products plus control
    typedef struct packed {
        logic                                        valid;
        logic [karatsubaPkg::TAG_WIDTH-1:0]          tag;
        logic [karatsubaPkg::LEAF_PP_LOW_WIDTH-1:0]  lowLow;
        logic [karatsubaPkg::LEAF_PP_CROSS_WIDTH-1:0] lowHigh;
        logic [karatsubaPkg::LEAF_PP_CROSS_WIDTH-1:0] highLow;
        logic [karatsubaPkg::LEAF_PP_HIGH_WIDTH-1:0] highHigh;
    } partialStage_t;

    // Operand chunks
    logic [karatsubaPkg::LEAF_CHUNK_LOW_WIDTH-1:0]  aLowChunk;
    logic [karatsubaPkg::LEAF_CHUNK_HIGH_WIDTH-1:0] aHighChunk;
    logic [karatsubaPkg::LEAF_CHUNK_LOW_WIDTH-1:0]  bLowChunk;
    logic [karatsubaPkg::LEAF_CHUNK_HIGH_WIDTH-1:0] bHighChunk;

    partialStage_t stageOneNext;
    partialStage_t stageOneQ;

    // Stage two terms, all at product width
    logic [karatsubaPkg::LEAF_CROSS_SUM_WIDTH-1:0] crossSum;
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0]   highTerm;
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0]   crossTerm;
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0]   lowTerm;
    karatsubaPkg::leafResult_t                     resultNext;

    // ==================================================
    // Stage one, chunk products
    // ==================================================
    assign aLowChunk  = job_i.operandA[karatsubaPkg::LEAF_CHUNK_LOW_WIDTH-1:0];
    assign aHighChunk = job_i.operandA[karatsubaPkg::LEAF_WIDTH-1 -:
                                       karatsubaPkg::LEAF_CHUNK_HIGH_WIDTH];
    assign bLowChunk  = job_i.operandB[karatsubaPkg::LEAF_CHUNK_LOW_WIDTH-1:0];
    assign bHighChunk = job_i.operandB[karatsubaPkg::LEAF_WIDTH-1 -:
                                       karatsubaPkg::LEAF_CHUNK_HIGH_WIDTH];

    always_comb begin
        stageOneNext.valid    = job_i.valid;
        stageOneNext.tag      = job_i.tag;
        // Each product sized to exactly fit its chunks
        stageOneNext.lowLow   = aLowChunk * bLowChunk;
        stageOneNext.lowHigh  = aLowChunk * bHighChunk;
        stageOneNext.highLow  = aHighChunk * bLowChunk;
        stageOneNext.highHigh = aHighChunk * bHighChunk;
    end

    always_ff @(posedge clk) begin
        stageOneQ <= stageOneNext;
        if (rst_i) begin
            stageOneQ.valid <= 1'b0;
        end
    end

    // ==================================================
    // Stage two, shift and sum
    // ==================================================
    assign crossSum = {1'b0, stageOneQ.lowHigh} + {1'b0, stageOneQ.highLow};

    // High chunk pair sits two chunk widths up
    assign highTerm = {stageOneQ.highHigh, {(2 * karatsubaPkg::LEAF_CHUNK_LOW_WIDTH){1'b0}}};
    // Cross sum sits one chunk width up
    assign crossTerm = {{(karatsubaPkg::LEAF_PRODUCT_WIDTH - karatsubaPkg::LEAF_CROSS_SUM_WIDTH
                         - karatsubaPkg::LEAF_CHUNK_LOW_WIDTH){1'b0}},
                        crossSum,
                        {karatsubaPkg::LEAF_CHUNK_LOW_WIDTH{1'b0}}};
    assign lowTerm = {{(karatsubaPkg::LEAF_PRODUCT_WIDTH - karatsubaPkg::LEAF_PP_LOW_WIDTH){1'b0}},
                      stageOneQ.lowLow};

    always_comb begin
        resultNext.valid   = stageOneQ.valid;
        resultNext.tag     = stageOneQ.tag;
        resultNext.product = highTerm + crossTerm + lowTerm;
    end

    always_ff @(posedge clk) begin
        result_o <= resultNext;
        if (rst_i) begin
            result_o.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/karatsubaRecombine.sv
module karatsubaRecombine (
    input  logic                                                      clk,
    input  logic                                                      rst_i,
    input  karatsubaPkg::leafResult_t [karatsubaPkg::NUM_LEAVES-1:0] results_i,
    output karatsubaPkg::mulResponse_t                                resp_o
);

    // Leaf products by role
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0] highProduct;
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0] lowProduct;
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0] sumProduct;

    // Middle term aH*bL + aL*bH, never negative
    logic [karatsubaPkg::LEAF_PRODUCT_WIDTH-1:0] middleTerm;

    // Terms placed at final width
    logic [karatsubaPkg::PRODUCT_WIDTH-1:0] highPlaced;
    logic [karatsubaPkg::PRODUCT_WIDTH-1:0] middlePlaced;
    logic [karatsubaPkg::PRODUCT_WIDTH-1:0] lowPlaced;

    karatsubaPkg::mulResponse_t respNext;

    assign highProduct = results_i[karatsubaPkg::LEAF_HIGH].product;
    assign lowProduct  = results_i[karatsubaPkg::LEAF_LOW].product;
    assign sumProduct  = results_i[karatsubaPkg::LEAF_SUM].product;

    // ==================================================
    // Middle term
    // ==================================================
    // Wraps in the intermediate, exact in the end
    assign middleTerm = sumProduct - highProduct - lowProduct;

    // ==================================================
    // Shift and add
    // ==================================================
    // High product holds at most 24 significant bits
    assign highPlaced = {highProduct[karatsubaPkg::PRODUCT_WIDTH - karatsubaPkg::OPERAND_WIDTH - 1:0],
                         {karatsubaPkg::OPERAND_WIDTH{1'b0}}};

    // Middle term one half width up
    assign middlePlaced = {{(karatsubaPkg::PRODUCT_WIDTH - karatsubaPkg::LEAF_PRODUCT_WIDTH
                            - karatsubaPkg::HALF_WIDTH){1'b0}},
                           middleTerm,
                           {karatsubaPkg::HALF_WIDTH{1'b0}}};

    assign lowPlaced = {{(karatsubaPkg::PRODUCT_WIDTH - karatsubaPkg::LEAF_PRODUCT_WIDTH){1'b0}},
                        lowProduct};

    always_comb begin
        // Control follows the high leaf, all three are in step
        respNext.valid   = results_i[karatsubaPkg::LEAF_HIGH].valid;
        respNext.tag     = results_i[karatsubaPkg::LEAF_HIGH].tag;
        respNext.product = highPlaced + middlePlaced + lowPlaced;
    end

    // Response register
    always_ff @(posedge clk) begin
        resp_o <= respNext;
        if (rst_i) begin
            resp_o.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/karatsubaMulTop.sv
module karatsubaMulTop (
    input  logic                       clk,
    input  logic                       rst_i,
    input  karatsubaPkg::mulRequest_t  req_i,
    output karatsubaPkg::mulResponse_t resp_o
);

    // Splitter to leaves
    karatsubaPkg::leafJob_t [karatsubaPkg::NUM_LEAVES-1:0] leafJobs;

    // Leaves to recombiner
    karatsubaPkg::leafResult_t [karatsubaPkg::NUM_LEAVES-1:0] leafResults;

    // ==================================================
    // Split stage, one cycle
    // ==================================================
    karatsubaSplitter i_splitter (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .jobs_o (leafJobs)
    );

    // ==================================================
    // Leaf multipliers, two cycles
    // ==================================================
    // High halves, low halves, half sums
    for (genvar leafIdx = 0; leafIdx < karatsubaPkg::NUM_LEAVES; leafIdx++) begin : gLeaf
        karatsubaLeaf i_leaf (
            .clk      (clk),
            .rst_i    (rst_i),
            .job_i    (leafJobs[leafIdx]),
            .result_o (leafResults[leafIdx])
        );
    end

    // ==================================================
    // Recombine stage, one cycle
    // ==================================================
    karatsubaRecombine i_recombine (
        .clk       (clk),
        .rst_i     (rst_i),
        .results_i (leafResults),
        .resp_o    (resp_o)
    );

endmodule

// File: testbench/karatsubaMulTop_sva.sv
module karatsubaMulTop_sva (
    input logic                                                      clk,
    input logic                                                      rst_i,
    input karatsubaPkg::mulRequest_t                                 req_i,
    input karatsubaPkg::mulResponse_t                                resp_o,
    input karatsubaPkg::leafResult_t [karatsubaPkg::NUM_LEAVES-1:0] leafResults
);

    // ==================================================
    // Pipeline timing
    // ==================================================
    latencyHolds: assert property (@(posedge clk) disable iff (rst_i)
        req_i.valid |-> ##(karatsubaPkg::PIPE_LATENCY) resp_o.valid)
        else $error("response did not follow request after the pipeline latency");

    // All three leaves run in lockstep
    leavesAgreeValid: assert property (@(posedge clk) disable iff (rst_i)
        (leafResults[karatsubaPkg::LEAF_HIGH].valid == leafResults[karatsubaPkg::LEAF_LOW].valid)
        && (leafResults[karatsubaPkg::LEAF_HIGH].valid
            == leafResults[karatsubaPkg::LEAF_SUM].valid))
        else $error("leaf result valid bits disagree");

    // Tags only meaningful with valid
    leavesAgreeTag: assert property (@(posedge clk) disable iff (rst_i)
        leafResults[karatsubaPkg::LEAF_HIGH].valid |->
            (leafResults[karatsubaPkg::LEAF_HIGH].tag == leafResults[karatsubaPkg::LEAF_LOW].tag)
            && (leafResults[karatsubaPkg::LEAF_HIGH].tag
                == leafResults[karatsubaPkg::LEAF_SUM].tag))
        else $error("leaf result tags disagree");

    // ==================================================
    // Reset
    // ==================================================
    resetClearsResp: assert property (@(posedge clk) rst_i |=> !resp_o.valid)
        else $error("response valid high in the cycle after reset");

endmodule

bind karatsubaMulTop karatsubaMulTop_sva i_karatsubaMulTopSva (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .resp_o      (resp_o),
    .leafResults (leafResults)
);

// File: testbench/karatsubaMulTb.sv
module karatsubaMulTb;

    // One scoreboard entry per accepted request
    typedef struct packed {
        logic [karatsubaPkg::TAG_WIDTH-1:0]     tag;
        logic [karatsubaPkg::PRODUCT_WIDTH-1:0] product;
        logic [31:0]                            dueCycle;
    } expectEntry_t;

    logic                       clk;
    logic                       rst_i;
    karatsubaPkg::mulRequest_t  req;
    karatsubaPkg::mulResponse_t resp;

    expectEntry_t                       expected[$];
    expectEntry_t                       head;
    logic [karatsubaPkg::TAG_WIDTH-1:0] nextTag;
    int                                 seed;
    int                                 cycleCount;
    // Stimulus spans roughly 800 cycles
    int                                 cycleLimit = 2000;
    int                                 valueErrors;
    int                                 protocolErrors;

    karatsubaMulTop i_karatsubaMulTop (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (req),
        .resp_o (resp)
    );

    // ==================================================
    // Clock and cycle counter
    // ==================================================
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Direct product, no splitting
    function automatic logic [karatsubaPkg::PRODUCT_WIDTH-1:0] refProduct(
        input logic [karatsubaPkg::OPERAND_WIDTH-1:0] a,
        input logic [karatsubaPkg::OPERAND_WIDTH-1:0] b
    );
        logic [karatsubaPkg::PRODUCT_WIDTH-1:0] wideA;
        logic [karatsubaPkg::PRODUCT_WIDTH-1:0] wideB;
        wideA = a;
        wideB = b;
        return wideA * wideB;
    endfunction

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic issueRequest(input logic [karatsubaPkg::OPERAND_WIDTH-1:0] a,
                                input logic [karatsubaPkg::OPERAND_WIDTH-1:0] b);
        expectEntry_t entry;
        @(posedge clk);
        #10;
        req.valid    = 1'b1;
        req.tag      = nextTag;
        req.operandA = a;
        req.operandB = b;
        // Due once the counter has moved PIPE_LATENCY edges on
        entry.tag      = nextTag;
        entry.product  = refProduct(a, b);
        entry.dueCycle = cycleCount + karatsubaPkg::PIPE_LATENCY;
        expected.push_back(entry);
        nextTag = nextTag + 1'b1;
    endtask

    task automatic issueRandom;
        logic [31:0] randA;
        logic [31:0] randB;
        randA = $random(seed);
        randB = $random(seed);
        issueRequest(randA[karatsubaPkg::OPERAND_WIDTH-1:0],
                     randB[karatsubaPkg::OPERAND_WIDTH-1:0]);
    endtask

    // Strobe low, operands left as noise
    task automatic idleCycle;
        logic [31:0] noiseA;
        logic [31:0] noiseB;
        noiseA = $random(seed);
        noiseB = $random(seed);
        @(posedge clk);
        #10;
        req.valid    = 1'b0;
        req.operandA = noiseA[karatsubaPkg::OPERAND_WIDTH-1:0];
        req.operandB = noiseB[karatsubaPkg::OPERAND_WIDTH-1:0];
    endtask

    task automatic resetMidStream;
        @(posedge clk);
        #10;
        rst_i     = 1'b1;
        req.valid = 1'b0;
        // First edge that samples reset, everything still queued is dropped
        @(posedge clk);
        expected.delete();
        @(negedge clk);
        if (resp.valid !== 1'b0) begin
            protocolErrors++;
            $display("response valid still high after reset at time %0t", $time);
        end
        repeat (2) @(posedge clk);
        #10;
        rst_i = 1'b0;
    endtask

    // ==================================================
    // Comparison, outputs settled by the falling edge
    // ==================================================
    always @(negedge clk) begin
        if (resp.valid === 1'b1) begin
            if (expected.size() == 0) begin
                protocolErrors++;
                $display("unexpected response with no request outstanding at time %0t", $time);
            end else begin
                head = expected.pop_front();
                if (resp.tag !== head.tag) begin
                    valueErrors++;
                    $display("FAILED at time %0t: tag %0d, expected %0d",
                             $time, resp.tag, head.tag);
                end
                if (resp.product !== head.product) begin
                    valueErrors++;
                    $display("FAILED at time %0t: tag %0d product %h, expected %h",
                             $time, head.tag, resp.product, head.product);
                end
                if (cycleCount != head.dueCycle) begin
                    valueErrors++;
                    $display("FAILED at time %0t: tag %0d arrived in cycle %0d, expected %0d",
                             $time, head.tag, cycleCount, head.dueCycle);
                end
            end
        end else if (expected.size() != 0 && expected[0].dueCycle <= cycleCount) begin
            protocolErrors++;
            $display("response for tag %0d did not arrive by cycle %0d",
                     expected[0].tag, expected[0].dueCycle);
            void'(expected.pop_front());
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        clk            = 1'b0;
        rst_i          = 1'b1;
        req            = '0;
        nextTag        = '0;
        seed           = 32'h07bd_3e12;
        cycleCount     = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        repeat (10) @(posedge clk);
        #10;
        rst_i = 1'b0;

        // Corner operands, back to back
        issueRequest(24'h000000, 24'h000000);
        issueRequest(24'h000000, 24'hffffff);
        issueRequest(24'h000001, 24'h000001);
        issueRequest(24'h000001, 24'hffffff);
        issueRequest(24'hffffff, 24'h000001);
        issueRequest(24'hffffff, 24'hffffff);
        issueRequest(24'h800000, 24'h800000);
        issueRequest(24'h800000, 24'h000001);
        issueRequest(24'hffffff, 24'h800000);

        // Full rate random stream, tags wrap many times
        repeat (500) issueRandom();
        idleCycle();

        // Random gaps in the strobe
        repeat (200) begin
            if ($random(seed) & 1) begin
                issueRandom();
            end else begin
                idleCycle();
            end
        end

        // Reset with requests in flight, then recovery
        repeat (20) issueRandom();
        resetMidStream();
        repeat (30) issueRandom();

        repeat (karatsubaPkg::PIPE_LATENCY + 2) idleCycle();
        if (expected.size() != 0) begin
            protocolErrors++;
            $display("responses missing at end of test, %0d outstanding", expected.size());
        end
        $display("Summary: %0d value errors, %0d protocol errors", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
        end
        $display("run stopped after %0d cycles without finishing", cycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verilog.f
verilog/karatsubaPkg.sv
verilog/karatsubaSplitter.sv
verilog/karatsubaLeaf.sv
verilog/karatsubaRecombine.sv
verilog/karatsubaMulTop.sv
testbench/karatsubaMulTop_sva.sv
testbench/karatsubaMulTb.sv

// File: Bender.yml
package:
  name: karatsuba_mul

sources:
  - target: any(rtl, test)
    files:
      - verilog/karatsubaPkg.sv
      - verilog/karatsubaSplitter.sv
      - verilog/karatsubaLeaf.sv
      - verilog/karatsubaRecombine.sv
      - verilog/karatsubaMulTop.sv
  - target: test
    files:
      - testbench/karatsubaMulTop_sva.sv
      - testbench/karatsubaMulTb.sv
